//--- Makefile
# Verilator build and run for the paced queue

TOP := tb_paced_queue

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- apb_reg_fsm.sv
/* APB register block */

`timescale 1ns/1ps

module apb_reg_fsm (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  pacer_pkg::apb_req_t             apb_req_i,
    output pacer_pkg::apb_rsp_t             apb_rsp_o,
    input  pacer_pkg::queue_status_t        status_i,
    input  logic [pacer_pkg::SENT_W-1:0]    sent_i,
    output logic                            push_o,
    output logic [pacer_pkg::DATA_W-1:0]    wdata_o,
    output logic                            flush_o,
    output pacer_pkg::ctrl_t                ctrl_o
);

    // state records the phase of the previous cycle
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_e;

    state_e state_q;
    state_e state_d;

    logic setup_phase;
    logic access_phase;
    logic valid_access;
    logic wr_en;
    logic hit_data;
    logic hit_interval;
    logic hit_status;
    logic hit_ctrl;
    logic mapped;
    logic [pacer_pkg::DATA_W-1:0] rdata;
    pacer_pkg::ctrl_t ctrl_q;

    assign setup_phase  = apb_req_i.psel & ~apb_req_i.penable;
    assign access_phase = apb_req_i.psel & apb_req_i.penable;
    // an access only counts when a setup cycle came right before it
    assign valid_access = access_phase & (state_q == ST_SETUP);

    // address decode
    assign hit_data     = (apb_req_i.paddr == pacer_pkg::ADDR_DATA);
    assign hit_interval = (apb_req_i.paddr == pacer_pkg::ADDR_INTERVAL);
    assign hit_status   = (apb_req_i.paddr == pacer_pkg::ADDR_STATUS);
    assign hit_ctrl     = (apb_req_i.paddr == pacer_pkg::ADDR_CTRL);
    assign mapped       = hit_data | hit_interval | hit_status | hit_ctrl;

    assign wr_en = valid_access & apb_req_i.pwrite;

    always_comb begin
        state_d = ST_IDLE;
        case (state_q)
            ST_IDLE:   state_d = setup_phase ? ST_SETUP : ST_IDLE;
            ST_SETUP: begin
                if (access_phase) state_d = ST_ACCESS;
                else if (setup_phase) state_d = ST_SETUP;
                else state_d = ST_IDLE;
            end
            // back to back transfers go straight into a new setup
            ST_ACCESS: state_d = setup_phase ? ST_SETUP : ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    // read mux, zero outside a read access
    always_comb begin
        rdata = '0;
        if (valid_access && !apb_req_i.pwrite) begin
            if (hit_status) begin
                rdata = {sent_i, 8'h00, status_i.usage, 2'b00, status_i.full, status_i.empty};
            end else if (hit_interval) begin
                rdata[pacer_pkg::INTERVAL_W-1:0] = ctrl_q.interval;
            end else if (hit_ctrl) begin
                rdata[0] = ctrl_q.enable;
            end
        end
    end

    // every access cycle completes at once
    assign apb_rsp_o.pready  = access_phase;
    assign apb_rsp_o.prdata  = rdata;
    // bad phase order, unmapped address or a write into a full queue
    assign apb_rsp_o.pslverr = access_phase &
        (~valid_access | ~mapped | (apb_req_i.pwrite & hit_data & status_i.full));

    assign push_o  = wr_en & hit_data & ~status_i.full;
    assign wdata_o = apb_req_i.pwdata;
    assign flush_o = wr_en & hit_ctrl & apb_req_i.pwdata[1];
    assign ctrl_o  = ctrl_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            ctrl_q  <= '0;
        end else begin
            state_q <= state_d;
            if (wr_en && hit_interval) begin
                ctrl_q.interval <= apb_req_i.pwdata[pacer_pkg::INTERVAL_W-1:0];
            end
            if (wr_en && hit_ctrl) begin
                ctrl_q.enable <= apb_req_i.pwdata[0];
            end
        end
    end

endmodule

//--- list.f
pacer_pkg.sv
pace_fifo.sv
apb_reg_fsm.sv
pace_timer.sv
pace_out.sv
paced_queue_top.sv
paced_queue_sva.sv
tb_paced_queue.sv

//--- pace_fifo.sv
/* Circular buffer queue */

`timescale 1ns/1ps

module pace_fifo (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  logic                            push_i,
    input  logic [pacer_pkg::DATA_W-1:0]    data_i,
    input  logic                            pop_i,
    output logic [pacer_pkg::DATA_W-1:0]    data_o,
    output pacer_pkg::queue_status_t        status_o
);

    // read and write pointers, wrap at the queue depth
    logic [pacer_pkg::PTR_W-1:0] rd_ptr_q;
    logic [pacer_pkg::PTR_W-1:0] rd_ptr_d;
    logic [pacer_pkg::PTR_W-1:0] wr_ptr_q;
    logic [pacer_pkg::PTR_W-1:0] wr_ptr_d;

    // occupancy count, status flags come from here
    logic [pacer_pkg::USAGE_W-1:0] cnt_q;
    logic [pacer_pkg::USAGE_W-1:0] cnt_d;

    // storage array
    logic [pacer_pkg::DATA_W-1:0] mem_q [pacer_pkg::QUEUE_DEPTH];

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full  = (cnt_q == pacer_pkg::FULL_COUNT);
    assign empty = (cnt_q == '0);

    // a push into a full queue or a pop from an empty one is dropped here
    assign do_push = push_i & ~full;
    assign do_pop  = pop_i & ~empty;

    // head word is always the entry under the read pointer
    assign data_o = mem_q[rd_ptr_q];

    assign status_o.full  = full;
    assign status_o.empty = empty;
    assign status_o.usage = cnt_q;

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        if (do_push) begin
            wr_ptr_d = (wr_ptr_q == pacer_pkg::LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
        end
        if (do_pop) begin
            rd_ptr_d = (rd_ptr_q == pacer_pkg::LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
        end

        // push and pop together leave the count alone
        case ({do_push, do_pop})
            2'b10:   cnt_d = cnt_q + 1'b1;
            2'b01:   cnt_d = cnt_q - 1'b1;
            default: cnt_d = cnt_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush beats any push or pop in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // memory only changes on an accepted push
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

//--- pace_out.sv
/* Stream output stage */

`timescale 1ns/1ps

module pace_out (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  pacer_pkg::ctrl_t                ctrl_i,
    input  pacer_pkg::queue_status_t        status_i,
    input  logic [pacer_pkg::DATA_W-1:0]    head_i,
    input  logic                            release_ok_i,
    output logic                            pop_o,
    output logic                            reload_o,
    output logic [pacer_pkg::DATA_W-1:0]    data_o,
    output logic                            valid_o,
    input  logic                            ready_i,
    output logic [pacer_pkg::SENT_W-1:0]    sent_o
);

    logic                          hold_valid_q;
    logic [pacer_pkg::DATA_W-1:0]  hold_data_q;
    logic [pacer_pkg::SENT_W-1:0]  sent_q;
    logic                          accept;
    logic                          release_now;

    // word leaves on valid and ready together
    assign accept = hold_valid_q & ready_i;

    // hold register must be free or draining this cycle
    assign release_now = ctrl_i.enable & release_ok_i & ~status_i.empty &
                         (~hold_valid_q | accept);

    // pop the queue and restart the gap on the same cycle
    assign pop_o    = release_now;
    assign reload_o = release_now;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hold_valid_q <= 1'b0;
            sent_q       <= '0;
        end else begin
            if (release_now) begin
                hold_valid_q <= 1'b1;
            end else if (accept) begin
                hold_valid_q <= 1'b0;
            end
            // wraps at 16 bits
            if (accept) begin
                sent_q <= sent_q + 1'b1;
            end
        end
    end

    // payload only, qualified by hold_valid_q
    always_ff @(posedge clk_i) begin
        if (release_now) begin
            hold_data_q <= head_i;
        end
    end

    assign data_o  = hold_data_q;
    assign valid_o = hold_valid_q;
    assign sent_o  = sent_q;

endmodule

//--- pace_timer.sv
/* Release interval timer */

`timescale 1ns/1ps

module pace_timer (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [pacer_pkg::INTERVAL_W-1:0]    interval_i,
    input  logic                                reload_i,
    output logic                                ready_to_release_o
);

    // cycles left before the next release may go
    logic [pacer_pkg::INTERVAL_W-1:0] count_q;
    logic [pacer_pkg::INTERVAL_W-1:0] count_d;

    always_comb begin
        count_d = count_q;
        if (reload_i) begin
            // start a fresh gap at every release
            count_d = interval_i;
        end else if (count_q != '0) begin
            count_d = count_q - 1'b1;
        end
        // otherwise parked at zero, stays ready under back-pressure
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            // ready straight out of reset
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    // interval N gives ready again N cycles after the reload
    assign ready_to_release_o = (count_q == '0);

endmodule

//--- paced_queue_sva.sv
/* Paced queue assertions */

`timescale 1ns/1ps

module paced_queue_sva (
    input logic                             clk_i,
    input logic                             rst_ni,
    input pacer_pkg::apb_req_t              apb_req_i,
    input pacer_pkg::apb_rsp_t              apb_rsp_i,
    input logic [pacer_pkg::DATA_W-1:0]     data_i,
    input logic                             valid_i,
    input logic                             ready_i,
    input pacer_pkg::queue_status_t         status_i
);

    // no wait states on APB
    pready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (apb_req_i.psel && apb_req_i.penable) |-> apb_rsp_i.pready)
        else $error("pready low in an APB access cycle");

    // stalled word must not change
    stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i && !ready_i) |=> (valid_i && $stable(data_i)))
        else $error("stream word changed under back-pressure");

    // nothing to send from an empty queue and an empty hold register
    idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (status_i.empty && !valid_i) |=> !valid_i)
        else $error("stream output with queue and hold register empty");

endmodule

bind paced_queue_top paced_queue_sva i_paced_queue_sva (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req_i),
    .apb_rsp_i (apb_rsp_o),
    .data_i    (data_o),
    .valid_i   (valid_o),
    .ready_i   (ready_i),
    .status_i  (status)
);

//--- paced_queue_top.sv
/* Paced transmit queue */

`timescale 1ns/1ps

module paced_queue_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  pacer_pkg::apb_req_t             apb_req_i,
    output pacer_pkg::apb_rsp_t             apb_rsp_o,
    output logic [pacer_pkg::DATA_W-1:0]    data_o,
    output logic                            valid_o,
    input  logic                            ready_i
);

    // register block to queue
    logic                           push;
    logic [pacer_pkg::DATA_W-1:0]   wdata;
    logic                           flush;
    pacer_pkg::ctrl_t               ctrl;

    // queue status and head word
    pacer_pkg::queue_status_t       status;
    logic [pacer_pkg::DATA_W-1:0]   head;

    // output stage handshakes
    logic                           pop;
    logic                           reload;
    logic                           release_ok;
    logic [pacer_pkg::SENT_W-1:0]   sent;

    apb_reg_fsm i_apb_reg_fsm (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .status_i  (status),
        .sent_i    (sent),
        .push_o    (push),
        .wdata_o   (wdata),
        .flush_o   (flush),
        .ctrl_o    (ctrl)
    );

    pace_fifo i_pace_fifo (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .flush_i  (flush),
        .push_i   (push),
        .data_i   (wdata),
        .pop_i    (pop),
        .data_o   (head),
        .status_o (status)
    );

    pace_timer i_pace_timer (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .interval_i         (ctrl.interval),
        .reload_i           (reload),
        .ready_to_release_o (release_ok)
    );

    pace_out i_pace_out (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ctrl_i       (ctrl),
        .status_i     (status),
        .head_i       (head),
        .release_ok_i (release_ok),
        .pop_o        (pop),
        .reload_o     (reload),
        .data_o       (data_o),
        .valid_o      (valid_o),
        .ready_i      (ready_i),
        .sent_o       (sent)
    );

endmodule

//--- pacer_pkg.sv
/* Paced queue shared definitions */

package pacer_pkg;

    // width of one queued word
    localparam int unsigned DATA_W = 32;
    // number of queue entries
    localparam int unsigned QUEUE_DEPTH = 8;
    // pointer width into the queue memory
    localparam int unsigned PTR_W = 3;
    // usage count holds 0 .. QUEUE_DEPTH
    localparam int unsigned USAGE_W = 4;
    // interval register width
    localparam int unsigned INTERVAL_W = 16;
    // sent word counter width, wraps
    localparam int unsigned SENT_W = 16;
    // APB address width
    localparam int unsigned ADDR_W = 12;

    // count value when every entry is occupied
    localparam logic [USAGE_W-1:0] FULL_COUNT = USAGE_W'(QUEUE_DEPTH);
    // last pointer value before wrap
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);

    // register offsets
    localparam logic [ADDR_W-1:0] ADDR_DATA     = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_INTERVAL = 12'h004;
    localparam logic [ADDR_W-1:0] ADDR_STATUS   = 12'h008;
    localparam logic [ADDR_W-1:0] ADDR_CTRL     = 12'h00C;

    // APB request from the bus master
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // APB response back to the master
    typedef struct packed {
        logic              pready;
        logic              pslverr;
        logic [DATA_W-1:0] prdata;
    } apb_rsp_t;

    // software control, flush is a strobe and lives elsewhere
    typedef struct packed {
        logic                  enable;
        logic [INTERVAL_W-1:0] interval;
    } ctrl_t;

    // queue occupancy flags
    typedef struct packed {
        logic               full;
        logic               empty;
        logic [USAGE_W-1:0] usage;
    } queue_status_t;

endpackage

//--- tb_paced_queue.sv
/* Paced queue testbench */

`timescale 1ns/1ps

module tb_paced_queue;

    // step kinds of the stimulus table
    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_PUSH,
        OP_READY,
        OP_GAP,
        OP_IDLE,
        OP_DRAIN
    } op_e;

    // data is the word count for pushes, the cycle count for idles, the mode for ready
    typedef struct packed {
        op_e         op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic        err;
    } step_t;

    localparam logic [15:0] SEED   = 16'd39454;
    localparam int          MARGIN = 2000;
    localparam logic [11:0] A_INTV = pacer_pkg::ADDR_INTERVAL;
    localparam logic [11:0] A_STAT = pacer_pkg::ADDR_STATUS;
    localparam logic [11:0] A_CTRL = pacer_pkg::ADDR_CTRL;

    logic                clk_i;
    logic                rst_ni;
    logic                ready_i = 1'b0;
    logic                valid_o;
    logic [31:0]         data_o;
    pacer_pkg::apb_req_t apb_req;
    pacer_pkg::apb_rsp_t apb_rsp;

    step_t       steps [$];
    string       names [$];
    // every accepted push in order, the monitor walks it by index
    logic [31:0] model [$];
    logic [15:0] data_lfsr = SEED;
    logic [15:0] ready_lfsr = SEED;
    logic [1:0]  ready_mode = 2'd0;
    string       cur_name = "reset";
    int          dropped = 0;
    int          min_gap = 0;
    int          seen = 0;
    int          gap_used = 0;
    int          last_accept = 0;
    logic        have_last = 1'b0;
    int          cycle_cnt = 0;
    int          limit = 0;

    paced_queue_top i_paced_queue_top (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .data_o    (data_o),
        .valid_o   (valid_o),
        .ready_i   (ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, new bit enters at the bottom
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // STATUS: sent in 31:16, usage in 7:4, full in bit 1, empty in bit 0
    function automatic logic [31:0] status_word(input int sent, input int usage,
                                                input logic full, input logic empty);
        logic [31:0] w;
        w = '0;
        w[31:16] = sent[15:0];
        w[7:4] = usage[3:0];
        w[1] = full;
        w[0] = empty;
        return w;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "%s", msg);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %08h actual %08h", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic add_step(input op_e op, input logic [11:0] addr, input logic [31:0] data,
                            input logic [31:0] exp, input logic err, input string name);
        step_t s;
        s.op = op;
        s.addr = addr;
        s.data = data;
        s.exp = exp;
        s.err = err;
        steps.push_back(s);
        names.push_back(name);
    endtask

    // one word from 32 single LFSR steps
    task automatic next_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            w = {w[30:0], data_lfsr[0]};
        end
    endtask

    // setup and access phases, response sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk_i);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk_i);
        apb_req.penable <= 1'b1;
        @(negedge clk_i);
        check({cur_name, " pready"}, 32'd1, 32'(apb_rsp.pready));
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk_i);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic build_table();
        add_step(OP_READY, '0, 32'd0, '0, 1'b0, "ready_high");
        add_step(OP_RD, A_STAT, '0, status_word(0, 0, 1'b0, 1'b1), 1'b0, "reset_status");
        add_step(OP_RD, A_CTRL, '0, 32'd0, 1'b0, "reset_ctrl");
        add_step(OP_RD, A_INTV, '0, 32'd0, 1'b0, "reset_interval");
        // words wait in the queue until enable
        add_step(OP_PUSH, '0, 32'd5, '0, 1'b0, "push_five");
        add_step(OP_IDLE, '0, 32'd20, '0, 1'b0, "hold_disabled");
        add_step(OP_RD, A_STAT, '0, status_word(0, 5, 1'b0, 1'b0), 1'b0, "usage_five");
        add_step(OP_WR, A_CTRL, 32'd1, '0, 1'b0, "enable_five");
        add_step(OP_DRAIN, '0, '0, '0, 1'b0, "drain_five");
        add_step(OP_RD, A_STAT, '0, status_word(5, 0, 1'b0, 1'b1), 1'b0, "sent_five");
        // ninth word finds the queue full
        add_step(OP_WR, A_CTRL, 32'd0, '0, 1'b0, "disable_full");
        add_step(OP_PUSH, '0, 32'd8, '0, 1'b0, "push_eight");
        add_step(OP_PUSH, '0, 32'd1, '0, 1'b1, "push_ninth");
        add_step(OP_RD, A_STAT, '0, status_word(5, 8, 1'b1, 1'b0), 1'b0, "status_full");
        add_step(OP_WR, A_CTRL, 32'd1, '0, 1'b0, "enable_full");
        add_step(OP_DRAIN, '0, '0, '0, 1'b0, "drain_eight");
        add_step(OP_RD, A_STAT, '0, status_word(13, 0, 1'b0, 1'b1), 1'b0, "sent_thirteen");
        // interval 6 means accepts at least 7 cycles apart
        add_step(OP_WR, A_CTRL, 32'd0, '0, 1'b0, "disable_paced");
        add_step(OP_PUSH, '0, 32'd4, '0, 1'b0, "push_paced");
        add_step(OP_WR, A_INTV, 32'd6, '0, 1'b0, "interval_six");
        add_step(OP_RD, A_INTV, '0, 32'd6, 1'b0, "read_interval");
        add_step(OP_GAP, '0, 32'd7, '0, 1'b0, "gap_seven");
        add_step(OP_WR, A_CTRL, 32'd1, '0, 1'b0, "enable_paced");
        add_step(OP_DRAIN, '0, '0, '0, 1'b0, "drain_paced");
        add_step(OP_GAP, '0, 32'd0, '0, 1'b0, "gap_off");
        add_step(OP_RD, A_STAT, '0, status_word(17, 0, 1'b0, 1'b1), 1'b0, "sent_paced");
        add_step(OP_RD, A_CTRL, '0, 32'd1, 1'b0, "read_enable");
        // random back-pressure, no gap
        add_step(OP_WR, A_INTV, 32'd0, '0, 1'b0, "interval_zero");
        add_step(OP_READY, '0, 32'd1, '0, 1'b0, "ready_random");
        add_step(OP_PUSH, '0, 32'd12, '0, 1'b0, "push_random");
        add_step(OP_DRAIN, '0, '0, '0, 1'b0, "drain_random");
        add_step(OP_READY, '0, 32'd0, '0, 1'b0, "ready_high");
        add_step(OP_RD, A_STAT, '0, status_word(29, 0, 1'b0, 1'b1), 1'b0, "sent_random");
        // flush drops the six queued words
        add_step(OP_WR, A_CTRL, 32'd0, '0, 1'b0, "disable_flush");
        add_step(OP_PUSH, '0, 32'd6, '0, 1'b0, "push_six");
        add_step(OP_RD, A_STAT, '0, status_word(29, 6, 1'b0, 1'b0), 1'b0, "usage_six");
        add_step(OP_WR, A_CTRL, 32'd2, '0, 1'b0, "flush");
        add_step(OP_RD, A_STAT, '0, status_word(29, 0, 1'b0, 1'b1), 1'b0, "flushed");
        add_step(OP_WR, A_CTRL, 32'd1, '0, 1'b0, "enable_flush");
        add_step(OP_IDLE, '0, 32'd20, '0, 1'b0, "idle_flushed");
        add_step(OP_RD, A_STAT, '0, status_word(29, 0, 1'b0, 1'b1), 1'b0, "no_output");
        add_step(OP_PUSH, '0, 32'd3, '0, 1'b0, "push_after");
        add_step(OP_DRAIN, '0, '0, '0, 1'b0, "drain_after");
        add_step(OP_RD, A_STAT, '0, status_word(32, 0, 1'b0, 1'b1), 1'b0, "sent_after");
    endtask

    // paced release per word plus its APB transfer, summed over the table
    function automatic int run_limit();
        int total;
        int intvl;
        int words;
        total = MARGIN;
        intvl = 0;
        foreach (steps[i]) begin
            if (steps[i].op == OP_WR && steps[i].addr == A_INTV) begin
                intvl = int'(steps[i].data[15:0]);
            end
            words = (steps[i].op == OP_PUSH || steps[i].op == OP_IDLE) ?
                    int'(steps[i].data) : 1;
            total += words * (intvl + 2) + words * 4;
        end
        return total;
    endfunction

    initial begin
        logic [31:0] rdata;
        logic [31:0] word;
        logic        err;
        step_t       s;
        rst_ni  = 1'b0;
        apb_req = '0;
        build_table();
        limit = run_limit();
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            cur_name = names[i];
            case (s.op)
                OP_WR: begin
                    apb_xfer(1'b1, s.addr, s.data, rdata, err);
                    check(cur_name, 32'(s.err), 32'(err));
                    // hold register is empty whenever the table flushes
                    if (s.addr == A_CTRL && s.data[1]) begin
                        dropped = model.size() - seen;
                    end
                end
                OP_RD: begin
                    apb_xfer(1'b0, s.addr, '0, rdata, err);
                    check(cur_name, 32'(s.err), 32'(err));
                    check(cur_name, s.exp, rdata);
                    if (s.addr == A_STAT) begin
                        check({cur_name, " sent count"}, 32'(seen[15:0]),
                              32'(rdata[31:16]));
                    end
                end
                OP_PUSH: begin
                    for (int n = 0; n < int'(s.data); n++) begin
                        next_word(word);
                        if (!s.err) begin
                            model.push_back(word);
                        end
                        apb_xfer(1'b1, pacer_pkg::ADDR_DATA, word, rdata, err);
                        check(cur_name, 32'(s.err), 32'(err));
                    end
                end
                OP_READY: ready_mode <= s.data[1:0];
                OP_GAP:   min_gap = int'(s.data);
                OP_IDLE:  repeat (int'(s.data)) @(posedge clk_i);
                OP_DRAIN: begin
                    while (seen + dropped < model.size()) @(posedge clk_i);
                end
                default:  report_failure("unknown step kind in the stimulus table");
            endcase
        end
        $display("NO ERRORS");
        $finish;
    end

    // ready pattern, random bits come one LFSR step each
    always @(posedge clk_i) begin
        if (ready_mode == 2'd1) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            ready_i <= ready_lfsr[0];
        end else begin
            ready_i <= 1'b1;
        end
    end

    // stream scoreboard, a word counts when valid and ready meet
    always @(negedge clk_i) begin
        if (rst_ni && valid_o && ready_i) begin
            if (seen + dropped >= model.size()) begin
                report_failure("stream output appeared with no word left to send");
            end else begin
                check(cur_name, model[seen + dropped], data_o);
                seen = seen + 1;
                if (min_gap != gap_used) begin
                    gap_used = min_gap;
                    have_last = 1'b0;
                end
                if (min_gap != 0 && have_last) begin
                    check({cur_name, " release gap"}, 32'd1,
                          32'(cycle_cnt - last_accept >= min_gap));
                end
                last_accept = cycle_cnt;
                have_last = 1'b1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > limit) begin
            $display("timeout, the run did not end within %0d cycles", limit);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

endmodule
